// File: rtl/obi_pkg.sv
`default_nettype none

package obi_pkg;

    // Byte address as seen on both buses
    typedef logic [31:0] addr_t;

    // Bus word for read and write data
    typedef logic [31:0] data_t;

    // One enable bit per byte lane of data_t
    typedef logic [3:0] be_t;

    // One line per interrupt source
    typedef logic [31:0] irq_vec_t;

    // Index into irq_vec_t
    typedef logic [4:0] irq_id_t;

endpackage : obi_pkg

`default_nettype wire

// File: rtl/mem_map_pkg.sv
`default_nettype none

package mem_map_pkg;

    import obi_pkg::*;

    // Register offset inside the peripheral window
    typedef logic [7:0] periph_offset_t;

    // -------------------------------------------------------------------------
    // Data side address map
    // -------------------------------------------------------------------------

    // Everything at or above this address goes to the peripherals
    localparam addr_t PERIPH_BASE = 32'h1000_0000;

    localparam periph_offset_t PRINT_OFFSET  = 8'h00;
    localparam periph_offset_t TIMER_OFFSET  = 8'h04;
    localparam periph_offset_t DEBUG_OFFSET  = 8'h08;
    localparam periph_offset_t STATUS_OFFSET = 8'h0C;
    localparam periph_offset_t EXIT_OFFSET   = 8'h10;

    // -------------------------------------------------------------------------
    // Values with a fixed meaning
    // -------------------------------------------------------------------------

    // Status word that marks the test as passed
    localparam data_t TEST_PASS_VALUE = 32'h1234_5678;

    // Interrupt line raised by the countdown timer
    localparam irq_id_t TIMER_IRQ_ID = 5'd7;

endpackage : mem_map_pkg

`default_nettype wire

// File: rtl/obi_bus_if.sv
`timescale 1ns/100ps
`default_nettype none

interface obi_bus_if import obi_pkg::*; ();

    // Request phase
    logic  req;
    logic  gnt;
    addr_t addr;
    logic  we;
    be_t   be;
    data_t wdata;

    // Response phase, one per accepted request
    logic  rvalid;
    data_t rdata;

    modport manager (
        output req, addr, we, be, wdata,
        input  gnt, rvalid, rdata
    );

    modport subordinate (
        input  req, addr, we, be, wdata,
        output gnt, rvalid, rdata
    );

endinterface : obi_bus_if

`default_nettype wire

// File: rtl/mem_port_if.sv
`timescale 1ns/100ps
`default_nettype none

interface mem_port_if import obi_pkg::*; ();

    logic  en;
    logic  we;
    be_t   be;
    addr_t addr;
    data_t wdata;
    // Valid in the cycle after en
    data_t rdata;

    modport requester (
        output en, we, be, addr, wdata,
        input  rdata
    );

    modport responder (
        input  en, we, be, addr, wdata,
        output rdata
    );

endinterface : mem_port_if

`default_nettype wire

// File: rtl/dp_ram.sv
`timescale 1ns/100ps
`default_nettype none

module dp_ram import obi_pkg::*; #(
    parameter int RAM_ADDR_WIDTH = 16
) (
    input  logic           clk_i,

    // Read-only port, used for instruction fetch
    input  logic           rd_en_i,
    input  addr_t          rd_addr_i,
    output data_t          rd_data_o,

    // Read/write port with byte enables
    mem_port_if.responder  data_port
);

    localparam int WORD_BITS = RAM_ADDR_WIDTH - 2;
    localparam int NUM_WORDS = 2 ** WORD_BITS;

    data_t                mem [NUM_WORDS];
    logic [WORD_BITS-1:0] rd_idx;
    logic [WORD_BITS-1:0] dp_idx;

    // Word index from the low byte-address bits
    assign rd_idx = rd_addr_i[RAM_ADDR_WIDTH-1:2];
    assign dp_idx = data_port.addr[RAM_ADDR_WIDTH-1:2];

    // Both ports in one block so a read sees the word before any
    // write landing on the same edge
    always_ff @(posedge clk_i) begin
        if (rd_en_i) begin
            rd_data_o <= mem[rd_idx];
        end

        if (data_port.en) begin
            data_port.rdata <= mem[dp_idx];
            if (data_port.we) begin
                for (int b = 0; b < $bits(be_t); b++) begin
                    if (data_port.be[b]) begin
                        mem[dp_idx][8*b +: 8] <= data_port.wdata[8*b +: 8];
                    end
                end
            end
        end
    end

endmodule : dp_ram

`default_nettype wire

// File: rtl/virt_periph.sv
`timescale 1ns/100ps
`default_nettype none

module virt_periph import obi_pkg::*, mem_map_pkg::*; (
    input  logic           clk_i,
    input  logic           rst_i,

    mem_port_if.responder  regs,

    // Interrupt handshake with the core
    input  logic           irq_ack_i,
    input  irq_id_t        irq_id_i,
    output irq_vec_t       irq_o,

    output logic           debug_req_o,

    output logic           print_valid_o,
    output logic [7:0]     print_char_o,

    output logic           tests_passed_o,
    output logic           tests_failed_o,
    output logic           exit_valid_o,
    output data_t          exit_value_o
);

    periph_offset_t offset;
    logic           wr;
    logic           timer_wr;
    logic           timer_fire;
    data_t          timer_cnt;
    logic           timer_irq;

    assign offset   = regs.addr[$bits(periph_offset_t)-1:0];
    assign wr       = regs.en & regs.we;
    assign timer_wr = wr & (offset == TIMER_OFFSET);

    // -------------------------------------------------------------------------
    // Countdown timer
    // -------------------------------------------------------------------------

    // The counter holds the cycles left before the interrupt is set, so a
    // load of N raises the line N cycles after the write is accepted
    assign timer_fire = timer_wr ? (regs.wdata == data_t'(1)) :
                                   (timer_cnt == data_t'(1));

    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            timer_cnt <= '0;
            timer_irq <= 1'b0;
        end else begin
            if (timer_wr) begin
                timer_cnt <= (regs.wdata == '0) ? '0 : regs.wdata - 1'b1;
            end else if (timer_cnt != '0) begin
                timer_cnt <= timer_cnt - 1'b1;
            end

            if (timer_fire) begin
                timer_irq <= 1'b1;
            end else if (irq_ack_i && (irq_id_i == TIMER_IRQ_ID)) begin
                timer_irq <= 1'b0;
            end
        end
    end

    always_comb begin
        irq_o               = '0;
        irq_o[TIMER_IRQ_ID] = timer_irq;
    end

    // -------------------------------------------------------------------------
    // Strobes and sticky status
    // -------------------------------------------------------------------------

    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            print_valid_o  <= 1'b0;
            debug_req_o    <= 1'b0;
            tests_passed_o <= 1'b0;
            tests_failed_o <= 1'b0;
            exit_valid_o   <= 1'b0;
        end else begin
            print_valid_o <= wr & (offset == PRINT_OFFSET);
            debug_req_o   <= wr & (offset == DEBUG_OFFSET);
            if (wr && (offset == STATUS_OFFSET)) begin
                if (regs.wdata == TEST_PASS_VALUE) begin
                    tests_passed_o <= 1'b1;
                end else begin
                    tests_failed_o <= 1'b1;
                end
            end
            if (wr && (offset == EXIT_OFFSET)) begin
                exit_valid_o <= 1'b1;
            end
        end
    end

    // Payload captured alongside the strobes
    always_ff @(posedge clk_i) begin
        if (wr && (offset == PRINT_OFFSET)) begin
            print_char_o <= regs.wdata[7:0];
        end
        if (wr && (offset == EXIT_OFFSET)) begin
            exit_value_o <= regs.wdata;
        end
        // Only the timer has anything to read back
        if (regs.en) begin
            regs.rdata <= (offset == TIMER_OFFSET) ? timer_cnt : '0;
        end
    end

endmodule : virt_periph

`default_nettype wire

// File: rtl/mm_ram.sv
`timescale 1ns/100ps
`default_nettype none

module mm_ram import obi_pkg::*, mem_map_pkg::*; #(
    parameter int RAM_ADDR_WIDTH = 16
) (
    input  logic           clk_i,
    input  logic           rst_i,

    obi_bus_if.subordinate instr_bus,
    obi_bus_if.subordinate data_bus,

    input  logic           irq_ack_i,
    input  irq_id_t        irq_id_i,
    output irq_vec_t       irq_o,

    output logic           debug_req_o,

    output logic           print_valid_o,
    output logic [7:0]     print_char_o,

    output logic           tests_passed_o,
    output logic           tests_failed_o,
    output logic           exit_valid_o,
    output data_t          exit_value_o
);

    mem_port_if ram_port ();
    mem_port_if periph_port ();

    logic instr_accept;
    logic data_accept;
    logic data_is_periph;
    logic data_sel_periph_q;
    logic instr_rvalid_q;
    logic data_rvalid_q;

    // -------------------------------------------------------------------------
    // Request side
    // -------------------------------------------------------------------------

    // No back-pressure on either port
    assign instr_bus.gnt = instr_bus.req;
    assign data_bus.gnt  = data_bus.req;

    assign instr_accept = instr_bus.req & instr_bus.gnt;
    assign data_accept  = data_bus.req & data_bus.gnt;

    // Address decode picks exactly one responder
    assign data_is_periph = (data_bus.addr >= PERIPH_BASE);

    assign ram_port.en    = data_accept & ~data_is_periph;
    assign ram_port.we    = data_bus.we;
    assign ram_port.be    = data_bus.be;
    assign ram_port.addr  = data_bus.addr;
    assign ram_port.wdata = data_bus.wdata;

    assign periph_port.en    = data_accept & data_is_periph;
    assign periph_port.we    = data_bus.we;
    assign periph_port.be    = data_bus.be;
    // Offset relative to the window base
    assign periph_port.addr  = data_bus.addr - PERIPH_BASE;
    assign periph_port.wdata = data_bus.wdata;

    // -------------------------------------------------------------------------
    // Response side
    // -------------------------------------------------------------------------

    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            instr_rvalid_q    <= 1'b0;
            data_rvalid_q     <= 1'b0;
            data_sel_periph_q <= 1'b0;
        end else begin
            instr_rvalid_q    <= instr_accept;
            data_rvalid_q     <= data_accept;
            data_sel_periph_q <= data_accept & data_is_periph;
        end
    end

    assign instr_bus.rvalid = instr_rvalid_q;
    assign data_bus.rvalid  = data_rvalid_q;
    assign data_bus.rdata   = data_sel_periph_q ? periph_port.rdata : ram_port.rdata;

    dp_ram #(
        .RAM_ADDR_WIDTH (RAM_ADDR_WIDTH)
    ) dp_ram_inst (
        .clk_i     (clk_i),
        .rd_en_i   (instr_accept),
        .rd_addr_i (instr_bus.addr),
        .rd_data_o (instr_bus.rdata),
        .data_port (ram_port)
    );

    virt_periph virt_periph_inst (
        .clk_i          (clk_i),
        .rst_i          (rst_i),
        .regs           (periph_port),
        .irq_ack_i      (irq_ack_i),
        .irq_id_i       (irq_id_i),
        .irq_o          (irq_o),
        .debug_req_o    (debug_req_o),
        .print_valid_o  (print_valid_o),
        .print_char_o   (print_char_o),
        .tests_passed_o (tests_passed_o),
        .tests_failed_o (tests_failed_o),
        .exit_valid_o   (exit_valid_o),
        .exit_value_o   (exit_value_o)
    );

endmodule : mm_ram

`default_nettype wire

// File: rtl/mem_wrap.sv
`timescale 1ns/100ps
`default_nettype none

module mem_wrap import obi_pkg::*; #(
    parameter int RAM_ADDR_WIDTH = 16
) (
    input  logic       clk_i,
    input  logic       rst_i,

    // Instruction fetch port, read only
    input  logic       instr_req_i,
    input  addr_t      instr_addr_i,
    output logic       instr_gnt_o,
    output logic       instr_rvalid_o,
    output data_t      instr_rdata_o,

    // Data port
    input  logic       data_req_i,
    input  logic       data_we_i,
    input  be_t        data_be_i,
    input  addr_t      data_addr_i,
    input  data_t      data_wdata_i,
    output logic       data_gnt_o,
    output logic       data_rvalid_o,
    output data_t      data_rdata_o,

    // Interrupts
    input  irq_vec_t   irq_ext_i,
    input  logic       irq_ack_i,
    input  irq_id_t    irq_id_i,
    output irq_vec_t   irq_o,

    // Debug request
    input  logic       debug_ext_i,
    output logic       debug_req_o,

    // Virtual peripheral status
    output logic       print_valid_o,
    output logic [7:0] print_char_o,
    output logic       tests_passed_o,
    output logic       tests_failed_o,
    output logic       exit_valid_o,
    output data_t      exit_value_o
);

    obi_bus_if instr_bus ();
    obi_bus_if data_bus ();

    irq_vec_t irq_periph;
    logic     debug_periph;

    // Fetches are whole-word reads
    assign instr_bus.req   = instr_req_i;
    assign instr_bus.addr  = {instr_addr_i[31:2], 2'b00};
    assign instr_bus.we    = 1'b0;
    assign instr_bus.be    = '1;
    assign instr_bus.wdata = '0;
    assign instr_gnt_o     = instr_bus.gnt;
    assign instr_rvalid_o  = instr_bus.rvalid;
    assign instr_rdata_o   = instr_bus.rdata;

    assign data_bus.req   = data_req_i;
    assign data_bus.addr  = data_addr_i;
    assign data_bus.we    = data_we_i;
    assign data_bus.be    = data_be_i;
    assign data_bus.wdata = data_wdata_i;
    assign data_gnt_o     = data_bus.gnt;
    assign data_rvalid_o  = data_bus.rvalid;
    assign data_rdata_o   = data_bus.rdata;

    // Peripheral sources merged with the external ones
    assign irq_o       = irq_ext_i | irq_periph;
    assign debug_req_o = debug_ext_i | debug_periph;

    mm_ram #(
        .RAM_ADDR_WIDTH (RAM_ADDR_WIDTH)
    ) mm_ram_inst (
        .clk_i          (clk_i),
        .rst_i          (rst_i),
        .instr_bus      (instr_bus),
        .data_bus       (data_bus),
        .irq_ack_i      (irq_ack_i),
        .irq_id_i       (irq_id_i),
        .irq_o          (irq_periph),
        .debug_req_o    (debug_periph),
        .print_valid_o  (print_valid_o),
        .print_char_o   (print_char_o),
        .tests_passed_o (tests_passed_o),
        .tests_failed_o (tests_failed_o),
        .exit_valid_o   (exit_valid_o),
        .exit_value_o   (exit_value_o)
    );

endmodule : mem_wrap

`default_nettype wire

// File: testbench/tb_vectors.svh
`ifndef TB_VECTORS_SVH
`define TB_VECTORS_SVH

// Operations the testbench applies, one per table row
typedef enum logic [3:0] {
    OP_WRITE,   // Data port write
    OP_READ,    // Data port read
    OP_FETCH,   // Instruction fetch
    OP_PAIR,    // Fetch and data read in the same cycle
    OP_BURST,   // Data reads, one per cycle
    OP_TIMER,   // Timer load and wait for the interrupt
    OP_ACK,     // Interrupt acknowledge
    OP_EXT,     // External interrupt and debug inputs
    OP_RESET
} op_t;

// The aux field is the fetch address for OP_PAIR, the word count for OP_BURST
// and the interrupt id for OP_ACK
typedef struct packed {
    op_t   op;
    logic  rnd;     // Write word comes from the random source
    addr_t addr;
    addr_t aux;
    data_t wdata;
    be_t   be;
    data_t exp;     // Peripheral read word, or timer line after OP_ACK
} vec_row_t;

localparam addr_t ADDR_PRINT  = PERIPH_BASE + addr_t'(PRINT_OFFSET);
localparam addr_t ADDR_TIMER  = PERIPH_BASE + addr_t'(TIMER_OFFSET);
localparam addr_t ADDR_DEBUG  = PERIPH_BASE + addr_t'(DEBUG_OFFSET);
localparam addr_t ADDR_STATUS = PERIPH_BASE + addr_t'(STATUS_OFFSET);
localparam addr_t ADDR_EXIT   = PERIPH_BASE + addr_t'(EXIT_OFFSET);

localparam int NUM_ROWS = 27;

// op, rnd, addr, aux, wdata, be, exp
localparam vec_row_t VECTORS [NUM_ROWS] = '{
    '{OP_WRITE, 1'b1, 32'h0000_0000, 32'h0, 32'h0, 4'hF, 32'h0},
    '{OP_WRITE, 1'b1, 32'h0000_0004, 32'h0, 32'h0, 4'hF, 32'h0},
    '{OP_WRITE, 1'b1, 32'h0000_0008, 32'h0, 32'h0, 4'hF, 32'h0},
    '{OP_WRITE, 1'b1, 32'h0000_0000, 32'h0, 32'h0, 4'h5, 32'h0},
    '{OP_WRITE, 1'b1, 32'h0000_0004, 32'h0, 32'h0, 4'hA, 32'h0},
    '{OP_WRITE, 1'b1, 32'h0000_0008, 32'h0, 32'h0, 4'h8, 32'h0},
    '{OP_WRITE, 1'b1, 32'h0000_0FFC, 32'h0, 32'h0, 4'hF, 32'h0},
    '{OP_READ,  1'b0, 32'h0000_0000, 32'h0, 32'h0, 4'hF, 32'h0},
    '{OP_READ,  1'b0, 32'h0000_0004, 32'h0, 32'h0, 4'hF, 32'h0},
    '{OP_FETCH, 1'b0, 32'h0000_0008, 32'h0, 32'h0, 4'hF, 32'h0},
    '{OP_PAIR,  1'b0, 32'h0000_0004, 32'h0000_0FFC, 32'h0, 4'hF, 32'h0},
    '{OP_BURST, 1'b0, 32'h0000_0000, 32'd3, 32'h0, 4'hF, 32'h0},
    '{OP_WRITE, 1'b0, ADDR_PRINT,  32'h0, 32'h1234_567A, 4'hF, 32'h0},
    '{OP_WRITE, 1'b0, ADDR_STATUS, 32'h0, TEST_PASS_VALUE, 4'hF, 32'h0},
    '{OP_WRITE, 1'b0, ADDR_EXIT,   32'h0, 32'h0000_00A5, 4'hF, 32'h0},
    '{OP_READ,  1'b0, ADDR_STATUS, 32'h0, 32'h0, 4'hF, 32'h0},
    '{OP_RESET, 1'b0, 32'h0, 32'h0, 32'h0, 4'h0, 32'h0},
    '{OP_READ,  1'b0, ADDR_TIMER,  32'h0, 32'h0, 4'hF, 32'h0},
    '{OP_WRITE, 1'b0, ADDR_STATUS, 32'h0, 32'hDEAD_BEEF, 4'hF, 32'h0},
    '{OP_TIMER, 1'b0, ADDR_TIMER,  32'h0, 32'd5, 4'hF, 32'h0},
    '{OP_ACK,   1'b0, 32'h0, 32'd3, 32'h0, 4'h0, 32'h1},
    '{OP_ACK,   1'b0, 32'h0, 32'd7, 32'h0, 4'h0, 32'h0},
    '{OP_TIMER, 1'b0, ADDR_TIMER,  32'h0, 32'd1, 4'hF, 32'h0},
    '{OP_ACK,   1'b0, 32'h0, 32'd7, 32'h0, 4'h0, 32'h0},
    '{OP_EXT,   1'b0, 32'h0, 32'h0, 32'h8000_0001, 4'h1, 32'h0},
    '{OP_EXT,   1'b0, 32'h0, 32'h0, 32'h0, 4'h0, 32'h0},
    '{OP_WRITE, 1'b1, ADDR_DEBUG,  32'h0, 32'h0, 4'hF, 32'h0}
};

`endif

// File: testbench/tb_mem_wrap.sv
`timescale 1ns/100ps
`default_nettype none

module tb_mem_wrap import obi_pkg::*, mem_map_pkg::*;;

    localparam int  RAM_ADDR_WIDTH = 12;
    localparam int  RESET_CYCLES   = 4;
    localparam real DRIVE_DELAY    = 0.5;

    logic       clk_i = 1'b0;
    logic       rst_i;
    logic       instr_req_i;
    addr_t      instr_addr_i;
    logic       instr_gnt_o;
    logic       instr_rvalid_o;
    data_t      instr_rdata_o;
    logic       data_req_i;
    logic       data_we_i;
    be_t        data_be_i;
    addr_t      data_addr_i;
    data_t      data_wdata_i;
    logic       data_gnt_o;
    logic       data_rvalid_o;
    data_t      data_rdata_o;
    irq_vec_t   irq_ext_i;
    logic       irq_ack_i;
    irq_id_t    irq_id_i;
    irq_vec_t   irq_o;
    logic       debug_ext_i;
    logic       debug_req_o;
    logic       print_valid_o;
    logic [7:0] print_char_o;
    logic       tests_passed_o;
    logic       tests_failed_o;
    logic       exit_valid_o;
    data_t      exit_value_o;

    `include "tb_vectors.svh"

    // Reference model state
    data_t shadow [2**(RAM_ADDR_WIDTH-2)];
    data_t rng_state = 32'd55;
    logic  exp_passed;
    logic  exp_failed;
    logic  exp_exit;
    data_t exp_exit_value;
    logic  exp_timer_irq;

    always #2 clk_i = ~clk_i;

    mem_wrap #(
        .RAM_ADDR_WIDTH (RAM_ADDR_WIDTH)
    ) mem_wrap_inst (
        .clk_i          (clk_i),
        .rst_i          (rst_i),
        .instr_req_i    (instr_req_i),
        .instr_addr_i   (instr_addr_i),
        .instr_gnt_o    (instr_gnt_o),
        .instr_rvalid_o (instr_rvalid_o),
        .instr_rdata_o  (instr_rdata_o),
        .data_req_i     (data_req_i),
        .data_we_i      (data_we_i),
        .data_be_i      (data_be_i),
        .data_addr_i    (data_addr_i),
        .data_wdata_i   (data_wdata_i),
        .data_gnt_o     (data_gnt_o),
        .data_rvalid_o  (data_rvalid_o),
        .data_rdata_o   (data_rdata_o),
        .irq_ext_i      (irq_ext_i),
        .irq_ack_i      (irq_ack_i),
        .irq_id_i       (irq_id_i),
        .irq_o          (irq_o),
        .debug_ext_i    (debug_ext_i),
        .debug_req_o    (debug_req_o),
        .print_valid_o  (print_valid_o),
        .print_char_o   (print_char_o),
        .tests_passed_o (tests_passed_o),
        .tests_failed_o (tests_failed_o),
        .exit_valid_o   (exit_valid_o),
        .exit_value_o   (exit_value_o)
    );

    // ------------------------------------------------------------------------
    // Checking and reference model
    // ------------------------------------------------------------------------

    task automatic report_failure(input string what);
        $display("%s", what);
        $display("ERRORS FOUND");
        $fatal(1);
    endtask

    task automatic check_word(input string name, input data_t expected, input data_t actual);
        if (actual !== expected) begin
            report_failure($sformatf("Fail at %0.1f ns: %s expected %h, got %h",
                                     $realtime, name, expected, actual));
        end
    endtask

    task automatic check_flag(input string name, input logic expected, input logic actual);
        if (actual !== expected) begin
            report_failure($sformatf("Fail at %0.1f ns: %s expected %b, got %b",
                                     $realtime, name, expected, actual));
        end
    endtask

    task automatic check_irq(input string name, input irq_vec_t expected,
                             input irq_vec_t actual);
        if (actual !== expected) begin
            report_failure($sformatf("Fail at %0.1f ns: %s expected %h, got %h",
                                     $realtime, name, expected, actual));
        end
    endtask

    function automatic data_t xorshift32(input data_t x);
        data_t v;
        v = x;
        v = v ^ (v << 13);
        v = v ^ (v >> 17);
        v = v ^ (v << 5);
        return v;
    endfunction

    function automatic int word_index(input addr_t addr);
        return int'(addr[RAM_ADDR_WIDTH-1:2]);
    endfunction

    // Only the enabled byte lanes take the new word
    function automatic data_t merge_bytes(input data_t old_word, input data_t new_word,
                                          input be_t be);
        data_t v;
        v = old_word;
        for (int b = 0; b < 4; b++) begin
            if (be[b]) begin
                v[8*b +: 8] = new_word[8*b +: 8];
            end
        end
        return v;
    endfunction

    function automatic irq_vec_t timer_bit(input logic pending);
        irq_vec_t v;
        v = '0;
        v[TIMER_IRQ_ID] = pending;
        return v;
    endfunction

    task automatic update_model(input addr_t addr, input data_t data, input be_t be);
        if (addr < PERIPH_BASE) begin
            shadow[word_index(addr)] = merge_bytes(shadow[word_index(addr)], data, be);
        end else if (addr == ADDR_STATUS) begin
            if (data == TEST_PASS_VALUE) begin
                exp_passed = 1'b1;
            end else begin
                exp_failed = 1'b1;
            end
        end else if (addr == ADDR_EXIT) begin
            exp_exit       = 1'b1;
            exp_exit_value = data;
        end
    endtask

    task automatic verify_status();
        check_flag("tests_passed_o", exp_passed, tests_passed_o);
        check_flag("tests_failed_o", exp_failed, tests_failed_o);
        check_flag("exit_valid_o", exp_exit, exit_valid_o);
        if (exp_exit) begin
            check_word("exit_value_o", exp_exit_value, exit_value_o);
        end
    endtask

    // ------------------------------------------------------------------------
    // Bus operations
    // ------------------------------------------------------------------------

    // Inputs change shortly after the rising edge, outputs are sampled on the falling one
    task automatic drive_edge();
        @(posedge clk_i);
        #(DRIVE_DELAY);
    endtask

    task automatic sample_point();
        @(negedge clk_i);
    endtask

    task automatic data_write(input addr_t addr, input data_t data, input be_t be);
        logic is_print;
        logic is_debug;
        is_print = (addr == ADDR_PRINT);
        is_debug = (addr == ADDR_DEBUG);
        drive_edge();
        data_req_i   = 1'b1;
        data_we_i    = 1'b1;
        data_addr_i  = addr;
        data_be_i    = be;
        data_wdata_i = data;
        sample_point();
        check_flag("data_gnt_o", 1'b1, data_gnt_o);
        check_flag("data_rvalid_o", 1'b0, data_rvalid_o);
        drive_edge();
        data_req_i = 1'b0;
        data_we_i  = 1'b0;
        sample_point();
        update_model(addr, data, be);
        check_flag("data_rvalid_o", 1'b1, data_rvalid_o);
        check_flag("print_valid_o", is_print, print_valid_o);
        if (is_print) begin
            check_word("print_char_o", data_t'(data[7:0]), data_t'(print_char_o));
        end
        check_flag("debug_req_o", is_debug | debug_ext_i, debug_req_o);
        verify_status();
        // Strobes last one cycle only
        drive_edge();
        sample_point();
        check_flag("data_rvalid_o", 1'b0, data_rvalid_o);
        check_flag("print_valid_o", 1'b0, print_valid_o);
        check_flag("debug_req_o", debug_ext_i, debug_req_o);
    endtask

    task automatic data_read(input addr_t addr, input data_t expected);
        drive_edge();
        data_req_i  = 1'b1;
        data_we_i   = 1'b0;
        data_addr_i = addr;
        data_be_i   = '1;
        sample_point();
        check_flag("data_gnt_o", 1'b1, data_gnt_o);
        check_flag("data_rvalid_o", 1'b0, data_rvalid_o);
        drive_edge();
        data_req_i = 1'b0;
        sample_point();
        check_flag("data_rvalid_o", 1'b1, data_rvalid_o);
        check_word("data_rdata_o", expected, data_rdata_o);
    endtask

    task automatic instr_fetch(input addr_t addr);
        drive_edge();
        instr_req_i  = 1'b1;
        instr_addr_i = addr;
        sample_point();
        check_flag("instr_gnt_o", 1'b1, instr_gnt_o);
        check_flag("instr_rvalid_o", 1'b0, instr_rvalid_o);
        drive_edge();
        instr_req_i = 1'b0;
        sample_point();
        check_flag("instr_rvalid_o", 1'b1, instr_rvalid_o);
        check_word("instr_rdata_o", shadow[word_index(addr)], instr_rdata_o);
    endtask

    task automatic paired_read(input addr_t daddr, input addr_t iaddr);
        drive_edge();
        instr_req_i  = 1'b1;
        instr_addr_i = iaddr;
        data_req_i   = 1'b1;
        data_we_i    = 1'b0;
        data_addr_i  = daddr;
        data_be_i    = '1;
        sample_point();
        check_flag("instr_gnt_o", 1'b1, instr_gnt_o);
        check_flag("data_gnt_o", 1'b1, data_gnt_o);
        drive_edge();
        instr_req_i = 1'b0;
        data_req_i  = 1'b0;
        sample_point();
        check_flag("instr_rvalid_o", 1'b1, instr_rvalid_o);
        check_flag("data_rvalid_o", 1'b1, data_rvalid_o);
        check_word("instr_rdata_o", shadow[word_index(iaddr)], instr_rdata_o);
        check_word("data_rdata_o", shadow[word_index(daddr)], data_rdata_o);
    endtask

    // Each response arrives while the next request is being granted
    task automatic burst_read(input addr_t base, input int count);
        for (int i = 0; i <= count; i++) begin
            drive_edge();
            data_req_i  = (i < count);
            data_we_i   = 1'b0;
            data_be_i   = '1;
            data_addr_i = base + addr_t'(4 * i);
            sample_point();
            if (i < count) begin
                check_flag("data_gnt_o", 1'b1, data_gnt_o);
            end
            if (i == 0) begin
                check_flag("data_rvalid_o", 1'b0, data_rvalid_o);
            end else begin
                check_flag("data_rvalid_o", 1'b1, data_rvalid_o);
                check_word("data_rdata_o", shadow[word_index(base + addr_t'(4 * (i - 1)))],
                           data_rdata_o);
            end
        end
    endtask

    task automatic timer_wait(input data_t load);
        drive_edge();
        data_req_i   = 1'b1;
        data_we_i    = 1'b1;
        data_addr_i  = ADDR_TIMER;
        data_be_i    = '1;
        data_wdata_i = load;
        sample_point();
        check_flag("data_gnt_o", 1'b1, data_gnt_o);
        for (int c = 1; c <= int'(load); c++) begin
            drive_edge();
            data_req_i = 1'b0;
            data_we_i  = 1'b0;
            sample_point();
            if (c == 1) begin
                check_flag("data_rvalid_o", 1'b1, data_rvalid_o);
            end
            exp_timer_irq = exp_timer_irq | (c == int'(load));
            check_irq("irq_o", irq_ext_i | timer_bit(exp_timer_irq), irq_o);
        end
        // Line stays up while nobody acknowledges it
        repeat (3) begin
            drive_edge();
            sample_point();
            check_irq("irq_o", irq_ext_i | timer_bit(exp_timer_irq), irq_o);
        end
    endtask

    task automatic acknowledge_irq(input irq_id_t id, input logic pending_after);
        drive_edge();
        irq_ack_i = 1'b1;
        irq_id_i  = id;
        sample_point();
        check_irq("irq_o", irq_ext_i | timer_bit(exp_timer_irq), irq_o);
        drive_edge();
        irq_ack_i = 1'b0;
        irq_id_i  = '0;
        sample_point();
        exp_timer_irq = pending_after;
        check_irq("irq_o", irq_ext_i | timer_bit(exp_timer_irq), irq_o);
    endtask

    task automatic drive_external(input irq_vec_t irq, input logic dbg);
        drive_edge();
        irq_ext_i   = irq;
        debug_ext_i = dbg;
        sample_point();
        check_irq("irq_o", irq | timer_bit(exp_timer_irq), irq_o);
        check_flag("debug_req_o", dbg, debug_req_o);
    endtask

    task automatic apply_reset();
        drive_edge();
        rst_i = 1'b1;
        repeat (RESET_CYCLES) begin
            drive_edge();
        end
        rst_i          = 1'b0;
        exp_passed     = 1'b0;
        exp_failed     = 1'b0;
        exp_exit       = 1'b0;
        exp_timer_irq  = 1'b0;
        sample_point();
        check_flag("instr_rvalid_o", 1'b0, instr_rvalid_o);
        check_flag("data_rvalid_o", 1'b0, data_rvalid_o);
        check_flag("print_valid_o", 1'b0, print_valid_o);
        check_flag("debug_req_o", debug_ext_i, debug_req_o);
        check_irq("irq_o", irq_ext_i, irq_o);
        verify_status();
    endtask

    task automatic run_row(input vec_row_t row);
        data_t wdata;
        wdata = row.wdata;
        if (row.rnd) begin
            rng_state = xorshift32(rng_state);
            wdata     = rng_state;
        end
        case (row.op)
            OP_WRITE: data_write(row.addr, wdata, row.be);
            OP_READ:  data_read(row.addr, (row.addr < PERIPH_BASE) ?
                                          shadow[word_index(row.addr)] : row.exp);
            OP_FETCH: instr_fetch(row.addr);
            OP_PAIR:  paired_read(row.addr, row.aux);
            OP_BURST: burst_read(row.addr, int'(row.aux));
            OP_TIMER: timer_wait(wdata);
            OP_ACK:   acknowledge_irq(irq_id_t'(row.aux), row.exp[0]);
            OP_EXT:   drive_external(wdata, row.be[0]);
            OP_RESET: apply_reset();
            default:  report_failure("Unknown operation in the stimulus table");
        endcase
    endtask

    // ------------------------------------------------------------------------
    // Main sequence and watchdog
    // ------------------------------------------------------------------------

    initial begin
        rst_i        = 1'b1;
        instr_req_i  = 1'b0;
        instr_addr_i = '0;
        data_req_i   = 1'b0;
        data_we_i    = 1'b0;
        data_be_i    = '0;
        data_addr_i  = '0;
        data_wdata_i = '0;
        irq_ext_i    = '0;
        irq_ack_i    = 1'b0;
        irq_id_i     = '0;
        debug_ext_i  = 1'b0;
        apply_reset();
        for (int i = 0; i < NUM_ROWS; i++) begin
            run_row(VECTORS[i]);
        end
        $display("NO ERRORS");
        $finish;
    end

    initial begin : watchdog
        int max_load;
        int limit;
        max_load = 0;
        for (int i = 0; i < NUM_ROWS; i++) begin
            if ((VECTORS[i].op == OP_TIMER) && (int'(VECTORS[i].wdata) > max_load)) begin
                max_load = int'(VECTORS[i].wdata);
            end
        end
        limit = NUM_ROWS * 40 + max_load;
        repeat (limit) @(posedge clk_i);
        report_failure($sformatf("Timeout, the run did not finish within %0d cycles", limit));
    end

endmodule : tb_mem_wrap

`default_nettype wire

// File: all.f
+incdir+testbench
rtl/obi_pkg.sv
rtl/mem_map_pkg.sv
rtl/obi_bus_if.sv
rtl/mem_port_if.sv
rtl/dp_ram.sv
rtl/virt_periph.sv
rtl/mm_ram.sv
rtl/mem_wrap.sv
testbench/tb_mem_wrap.sv

// File: run_sim.sh
#!/usr/bin/env bash
# Builds the mem_wrap testbench with Verilator and runs it

cd "$(dirname "$0")" || exit 1

BUILD_LOG=build.log
SIM_LOG=sim.log

verilator --binary -Wno-fatal --top-module tb_mem_wrap -f all.f -Mdir obj_dir \
    > "$BUILD_LOG" 2>&1
if [ $? -ne 0 ]; then
    echo "Build failed, see $BUILD_LOG"
    exit 1
fi

./obj_dir/Vtb_mem_wrap > "$SIM_LOG" 2>&1
sim_status=$?

if grep -q "ERRORS FOUND" "$SIM_LOG"; then
    echo "Simulation failed, see $SIM_LOG"
    exit 1
fi
if [ $sim_status -ne 0 ]; then
    echo "Simulator exited with status $sim_status, see $SIM_LOG"
    exit 1
fi

echo "Simulation passed"
exit 0
